//--- design/acia_pkg.sv
// shared types for the serial controller
// CRU bit addresses, register structs, frame states
// frame length helpers used by both frame machines

package acia_pkg;

  typedef logic [4:0] cru_addr_t;

  // ==================================================
  // CRU write addresses
  // ==================================================
  localparam cru_addr_t CRU_RESET     = 5'd31;
  localparam cru_addr_t CRU_XIENB     = 5'd19;
  localparam cru_addr_t CRU_RIENB     = 5'd18;
  localparam cru_addr_t CRU_RTSON     = 5'd16;
  localparam cru_addr_t CRU_LDCTL     = 5'd14;
  localparam cru_addr_t CRU_LRDR      = 5'd12;
  localparam cru_addr_t CRU_LXDR      = 5'd11;
  localparam cru_addr_t CRU_LAST_RATE = 5'd10;  // top bit of a rate register
  localparam cru_addr_t CRU_LAST_CTRL = 5'd7;   // top bit of ctrl / buffers

  // ==================================================
  // CRU read addresses
  // ==================================================
  localparam cru_addr_t RD_INT    = 5'd31;
  localparam cru_addr_t RD_FLAG   = 5'd30;
  localparam cru_addr_t RD_RTS    = 5'd26;
  localparam cru_addr_t RD_XSRE   = 5'd23;
  localparam cru_addr_t RD_XBRE   = 5'd22;
  localparam cru_addr_t RD_RBRL   = 5'd21;
  localparam cru_addr_t RD_XINT   = 5'd17;
  localparam cru_addr_t RD_RINT   = 5'd16;
  localparam cru_addr_t RD_RIN    = 5'd15;
  localparam cru_addr_t RD_RSBD   = 5'd14;
  localparam cru_addr_t RD_RFBD   = 5'd13;
  localparam cru_addr_t RD_RFER   = 5'd12;
  localparam cru_addr_t RD_ROVER  = 5'd11;
  localparam cru_addr_t RD_RPER   = 5'd10;
  localparam cru_addr_t RD_RCVERR = 5'd9;

  localparam int HALF_BIT_W = 13;

  typedef struct packed {
    logic [1:0] sbs;    // stop bits: 00 1.5, 01 2, 1x 1
    logic       penb;
    logic       podd;
    logic [1:0] spare;
    logic [1:0] rcl;    // 5 + rcl data bits
  } ctrl_t;

  typedef struct packed {
    logic       div8;   // set = eight times slower
    logic [9:0] count;
  } rate_t;

  typedef struct packed {
    logic xbre;
    logic xsre;
  } tx_status_t;

  typedef struct packed {
    logic rbrl;
    logic rsbd;
    logic rfbd;
    logic rover;
    logic rper;
    logic rfer;
  } rx_status_t;

  typedef enum logic [2:0] {IDLE, START1, START, BITS, PARITY, STOP} frame_state_e;

  // data field length in half-bits
  function automatic logic [4:0] data_half_bits(ctrl_t c);
    return 5'd10 + {2'b00, c.rcl, 1'b0};
  endfunction

  function automatic logic [4:0] stop_half_bits(ctrl_t c);
    case (c.sbs)
      2'b00:   return 5'd3;
      2'b01:   return 5'd4;
      default: return 5'd2;
    endcase
  endfunction

endpackage

//--- design/cru_regs.sv
// CRU write decoder and load-flag sequence
// control, rate and transmit buffer registers
// interrupt logic and 32-way read mux

`timescale 1ns/10ps

module cru_regs
  import acia_pkg::*;
(
  input  logic       CLK,
  input  logic       sig_reset,
  input  logic       n_ce,
  input  logic       cru_clk,
  input  logic       cru_out,
  input  cru_addr_t  s,
  input  tx_status_t tx_status,
  input  rx_status_t rx_status,
  input  logic [7:0] rbr,
  input  logic       rin,
  input  logic       n_rts,
  output ctrl_t      ctrl,
  output rate_t      xdr,
  output rate_t      rdr,
  output logic [7:0] xbr,
  output logic       tx_load_pulse,
  output logic       tx_reset,
  output logic       rx_reset,
  output logic       rtson,
  output logic       cru_in,
  output logic       n_int
);

  logic ldctl;
  logic lrdr;
  logic lxdr;
  logic rienb;
  logic xienb;
  logic cru_clk_q;
  logic wr_sel;
  logic wr_first;
  logic clk_fall;
  logic wr_data;
  logic wr_low8;
  logic wr_buf;
  logic soft_rst;
  logic rint;
  logic xint;
  logic intr;
  logic flag;
  logic rcverr;

  // ==================================================
  // write decode
  // ==================================================
  assign wr_sel   = ~n_ce & cru_clk;
  assign wr_first = wr_sel & ~cru_clk_q;          // first cycle of a write strobe
  assign clk_fall = cru_clk_q & ~cru_clk;
  assign wr_data  = wr_sel & (s <= CRU_LAST_RATE);
  assign wr_low8  = (s <= CRU_LAST_CTRL);
  assign wr_buf   = wr_data & wr_low8 & ~ldctl & ~lrdr & ~lxdr;
  assign soft_rst = wr_sel & (s == CRU_RESET);

  assign tx_load_pulse = wr_buf & wr_first & (s == CRU_LAST_CTRL);
  assign tx_reset      = soft_rst & wr_first;
  assign rx_reset      = wr_first & ((s == CRU_RESET) | (s == CRU_RIENB));

  // flag bits and load sequence
  always_ff @(posedge CLK)
  begin
    cru_clk_q <= cru_clk;
    if (sig_reset || soft_rst)
    begin
      ldctl <= 1'b1;
      lrdr  <= 1'b1;
      lxdr  <= 1'b1;
      rtson <= 1'b0;
      rienb <= 1'b0;
      xienb <= 1'b0;
    end
    else if (wr_sel)
    begin
      case (s)
        CRU_LXDR:  lxdr  <= cru_out;  // clearing ends xmit rate load
        CRU_LRDR:  lrdr  <= cru_out;
        CRU_LDCTL: ldctl <= cru_out;
        CRU_RTSON: rtson <= cru_out;
        CRU_RIENB: rienb <= cru_out;
        CRU_XIENB: xienb <= cru_out;
        default: ;
      endcase
    end
    else if (clk_fall)
    begin
      // advance load phase after the last bit of a register
      if (s == CRU_LAST_CTRL)
        ldctl <= 1'b0;
      else if (s == CRU_LAST_RATE && !ldctl)
        lrdr <= 1'b0;
    end
  end

  // control and rate registers
  always_ff @(posedge CLK)
  begin
    if (sig_reset || soft_rst)
    begin
      ctrl <= '0;
      xdr  <= '0;
      rdr  <= '0;
    end
    else if (wr_data)
    begin
      if (ldctl)
      begin
        if (wr_low8)
          ctrl[s[2:0]] <= cru_out;
      end
      else
      begin
        if (lrdr)
          rdr[s[3:0]] <= cru_out;
        if (lxdr)
          xdr[s[3:0]] <= cru_out;   // both when both flags set
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (wr_buf)
      xbr[s[2:0]] <= cru_out;
  end

  // ==================================================
  // interrupts and read mux
  // ==================================================
  assign rint   = rx_status.rbrl & rienb;
  assign xint   = tx_status.xbre & xienb;
  assign intr   = rint | xint;
  assign n_int  = ~intr;
  assign flag   = ldctl | lrdr | lxdr;
  assign rcverr = rx_status.rfer | rx_status.rover | rx_status.rper;

  always_comb
  begin
    case (s)
      RD_INT:    cru_in = intr;
      RD_FLAG:   cru_in = flag;
      RD_RTS:    cru_in = ~n_rts;
      RD_XSRE:   cru_in = tx_status.xsre;
      RD_XBRE:   cru_in = tx_status.xbre;
      RD_RBRL:   cru_in = rx_status.rbrl;
      RD_XINT:   cru_in = xint;
      RD_RINT:   cru_in = rint;
      RD_RIN:    cru_in = rin;              // raw line level
      RD_RSBD:   cru_in = rx_status.rsbd;
      RD_RFBD:   cru_in = rx_status.rfbd;
      RD_RFER:   cru_in = rx_status.rfer;
      RD_ROVER:  cru_in = rx_status.rover;
      RD_RPER:   cru_in = rx_status.rper;
      RD_RCVERR: cru_in = rcverr;
      default:   cru_in = wr_low8 ? rbr[s[2:0]] : 1'b0;
    endcase
  end

endmodule

//--- design/half_bit_timer.sv
// prescaler and reloadable half-bit counter
// one half_tick per half-bit period of the rate register

`timescale 1ns/10ps

module half_bit_timer
  import acia_pkg::*;
#(
  parameter int CLK_DIV = 100
)
(
  input  logic  CLK,
  input  logic  sig_reset,
  input  rate_t rate,
  input  logic  restart,
  output logic  half_tick
);

  localparam int PW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [PW-1:0]         presc;
  logic [HALF_BIT_W-1:0] cnt;
  logic                  tick;
  logic                  run;   // set once a frame machine has started us
  logic                  cnt_zero;

  assign tick      = (presc == '0);
  assign cnt_zero  = (cnt == '0);
  assign half_tick = run & cnt_zero;

  always_ff @(posedge CLK)
  begin
    if (sig_reset)
      presc <= '0;
    else if (tick)
      presc <= PW'(CLK_DIV - 1);
    else
      presc <= presc - 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (sig_reset)
    begin
      cnt <= '0;
      run <= 1'b0;
    end
    else
    begin
      if (restart)
        run <= 1'b1;
      if (restart || cnt_zero)
        cnt <= {rate.count, 3'b000};
      else if (tick)
        cnt <= cnt - (rate.div8 ? HALF_BIT_W'(1) : HALF_BIT_W'(8)); // fine or coarse
    end
  end

endmodule

//--- design/serial_tx.sv
// transmitter with RTS/CTS gating
// shift register and frame FSM

`timescale 1ns/10ps

module serial_tx
  import acia_pkg::*;
(
  input  logic       CLK,
  input  logic       sig_reset,
  input  logic       tx_reset,
  input  ctrl_t      ctrl,
  input  logic [7:0] xbr,
  input  logic       tx_load_pulse,
  input  logic       rtson,
  input  logic       n_cts,
  input  logic       half_tick,
  output logic       restart,
  output tx_status_t tx_status,
  output logic       xout,
  output logic       n_rts
);

  frame_state_e state;
  tx_status_t   st;
  logic [4:0]   bitctr;
  logic [4:0]   bitctr_dec;
  logic [7:0]   xsr;
  logic         par;
  logic         par_next;
  logic         xout_q;
  logic         rts;
  logic         start_go;
  logic         xsr_load;
  logic         xsr_shift;

  assign bitctr_dec = bitctr - 5'd1;
  assign par_next   = par ^ xsr[0];
  assign start_go   = (state == IDLE) & rtson & ~n_cts & ~st.xbre;
  assign restart    = tx_reset | start_go;

  // buffer moves to shift reg at end of start bit
  assign xsr_load  = (state == START) & half_tick & (bitctr_dec == 5'd0);
  assign xsr_shift = (state == BITS) & half_tick & ~bitctr_dec[0];

  always_ff @(posedge CLK)
  begin
    if (xsr_load)
      xsr <= xbr;
    else if (xsr_shift)
      xsr <= {1'b0, xsr[7:1]};  // lsb first
  end

  // ==================================================
  // frame FSM
  // ==================================================
  always_ff @(posedge CLK)
  begin
    if (sig_reset || tx_reset)
    begin
      state  <= IDLE;
      bitctr <= '0;
      par    <= 1'b0;
      xout_q <= 1'b1;   // mark
      rts    <= 1'b0;
      st     <= '{xbre: 1'b1, xsre: 1'b1};
    end
    else
    begin
      if (state == IDLE)
      begin
        rts <= rtson;
        if (start_go)
        begin
          state  <= START;
          xout_q <= 1'b0;
          bitctr <= 5'd2;
        end
      end
      else if (half_tick)
      begin
        bitctr <= bitctr_dec;
        case (state)
          START:
            if (bitctr_dec == 5'd0)
            begin
              state   <= BITS;
              bitctr  <= data_half_bits(ctrl);
              par     <= 1'b0;
              st.xsre <= 1'b0;
              st.xbre <= 1'b1;
            end
          BITS:
          begin
            if (!bitctr_dec[0])
              par <= par_next;
            if (bitctr_dec == 5'd0)
            begin
              if (ctrl.penb)
              begin
                xout_q <= par_next ^ ctrl.podd;
                state  <= PARITY;
                bitctr <= 5'd2;
              end
              else
              begin
                xout_q <= 1'b1;
                state  <= STOP;
                bitctr <= stop_half_bits(ctrl);
              end
            end
          end
          PARITY:
            if (bitctr_dec == 5'd0)
            begin
              xout_q <= 1'b1;
              state  <= STOP;
              bitctr <= stop_half_bits(ctrl);
            end
          STOP:
            if (bitctr_dec == 5'd0)
            begin
              st.xsre <= 1'b1;
              state   <= IDLE;
            end
          default: state <= IDLE;
        endcase
      end
      // new character always wins over the start-bit handoff
      if (tx_load_pulse)
        st.xbre <= 1'b0;
    end
  end

  assign xout      = (state == BITS) ? xsr[0] : xout_q;
  assign n_rts     = ~rts;
  assign tx_status = st;

endmodule

//--- design/serial_rx.sv
// receiver: line synchronizer, shift register, buffer
// frame FSM with start, parity, framing and overrun checks

`timescale 1ns/10ps

module serial_rx
  import acia_pkg::*;
(
  input  logic       CLK,
  input  logic       sig_reset,
  input  logic       rx_reset,
  input  ctrl_t      ctrl,
  input  logic       rin,
  input  logic       half_tick,
  output logic       restart,
  output rx_status_t rx_status,
  output logic [7:0] rbr
);

  frame_state_e state;
  rx_status_t   st;
  logic         rin_m;
  logic         rin_s;
  logic [4:0]   bitctr;
  logic [4:0]   bitctr_dec;
  logic [7:0]   rsr;
  logic         par;
  logic         par_next;
  logic         sample;
  logic         rbr_load;

  always_ff @(posedge CLK)
  begin
    rin_m <= rin;
    rin_s <= rin_m;   // two-flop sync
  end

  assign bitctr_dec = bitctr - 5'd1;
  assign par_next   = par ^ rin_s;
  assign restart    = rx_reset | ((state == START1) & ~rin_s);
  assign sample     = (state == BITS) & half_tick & ~bitctr_dec[0];
  assign rbr_load   = (state == STOP) & half_tick & (bitctr_dec == 5'd0);

  always_ff @(posedge CLK)
  begin
    if (sample)
      rsr <= {rin_s, rsr[7:1]};
  end

  // right-justify to the character length
  always_ff @(posedge CLK)
  begin
    if (rbr_load)
    begin
      case (ctrl.rcl)
        2'd3:    rbr <= rsr;
        2'd2:    rbr <= {1'b0, rsr[7:1]};
        2'd1:    rbr <= {2'b00, rsr[7:2]};
        default: rbr <= {3'b000, rsr[7:3]};
      endcase
    end
  end

  // ==================================================
  // frame FSM
  // ==================================================
  always_ff @(posedge CLK)
  begin
    if (sig_reset || rx_reset)
    begin
      state  <= IDLE;
      bitctr <= '0;
      par    <= 1'b0;
      st     <= '0;
    end
    else if (state == IDLE)
    begin
      st.rsbd <= 1'b0;
      st.rfbd <= 1'b0;
      if (rin_s)
        state <= START1;   // line at mark
    end
    else if (state == START1)
    begin
      if (!rin_s)
      begin
        state  <= START;
        bitctr <= 5'd1;    // half a bit to start-bit middle
      end
    end
    else if (half_tick)
    begin
      bitctr <= bitctr_dec;
      case (state)
        START:
          if (bitctr_dec == 5'd0)
          begin
            if (rin_s)
              state <= IDLE;   // glitch, not a start bit
            else
            begin
              state   <= BITS;
              bitctr  <= data_half_bits(ctrl);
              par     <= 1'b0;
              st.rsbd <= 1'b1;
            end
          end
        BITS:
        begin
          if (!bitctr_dec[0])
          begin
            par     <= par_next;
            st.rfbd <= 1'b1;
          end
          if (bitctr_dec == 5'd0)
          begin
            bitctr <= 5'd2;
            state  <= ctrl.penb ? PARITY : STOP;
          end
        end
        PARITY:
          if (bitctr_dec == 5'd0)
          begin
            par    <= par_next;
            state  <= STOP;
            bitctr <= 5'd2;
          end
        STOP:
          if (bitctr_dec == 5'd0)
          begin
            st.rover <= st.rbrl;
            st.rper  <= ctrl.penb & (par ^ ctrl.podd);
            st.rfer  <= ~rin_s;
            st.rbrl  <= 1'b1;
            state    <= IDLE;
          end
        default: state <= IDLE;
      endcase
    end
  end

  assign rx_status = st;

endmodule

//--- design/acia_top.sv
// serial controller top level
// register block, transmitter, receiver and two rate timers

`timescale 1ns/10ps

module acia_top
  import acia_pkg::*;
#(
  parameter int CLK_DIV = 100
)
(
  input  logic      CLK,
  input  logic      sig_reset,
  input  logic      n_ce,
  input  logic      cru_clk,
  input  logic      cru_out,
  input  cru_addr_t s,
  input  logic      n_cts,
  input  logic      rin,
  output logic      cru_in,
  output logic      n_int,
  output logic      n_rts,
  output logic      xout
);

  ctrl_t      ctrl;
  rate_t      xdr;
  rate_t      rdr;
  logic [7:0] xbr;
  logic [7:0] rbr;
  logic       tx_load_pulse;
  logic       tx_reset;
  logic       rx_reset;
  logic       rtson;
  tx_status_t tx_status;
  rx_status_t rx_status;
  logic       tx_restart;
  logic       rx_restart;
  logic       tx_half_tick;
  logic       rx_half_tick;

  cru_regs u_regs (
    .CLK           (CLK),
    .sig_reset     (sig_reset),
    .n_ce          (n_ce),
    .cru_clk       (cru_clk),
    .cru_out       (cru_out),
    .s             (s),
    .tx_status     (tx_status),
    .rx_status     (rx_status),
    .rbr           (rbr),
    .rin           (rin),
    .n_rts         (n_rts),
    .ctrl          (ctrl),
    .xdr           (xdr),
    .rdr           (rdr),
    .xbr           (xbr),
    .tx_load_pulse (tx_load_pulse),
    .tx_reset      (tx_reset),
    .rx_reset      (rx_reset),
    .rtson         (rtson),
    .cru_in        (cru_in),
    .n_int         (n_int)
  );

  // transmit side
  half_bit_timer #(.CLK_DIV(CLK_DIV)) u_tx_timer (
    .CLK       (CLK),
    .sig_reset (sig_reset),
    .rate      (xdr),
    .restart   (tx_restart),
    .half_tick (tx_half_tick)
  );

  serial_tx u_tx (
    .CLK           (CLK),
    .sig_reset     (sig_reset),
    .tx_reset      (tx_reset),
    .ctrl          (ctrl),
    .xbr           (xbr),
    .tx_load_pulse (tx_load_pulse),
    .rtson         (rtson),
    .n_cts         (n_cts),
    .half_tick     (tx_half_tick),
    .restart       (tx_restart),
    .tx_status     (tx_status),
    .xout          (xout),
    .n_rts         (n_rts)
  );

  // receive side
  half_bit_timer #(.CLK_DIV(CLK_DIV)) u_rx_timer (
    .CLK       (CLK),
    .sig_reset (sig_reset),
    .rate      (rdr),
    .restart   (rx_restart),
    .half_tick (rx_half_tick)
  );

  serial_rx u_rx (
    .CLK       (CLK),
    .sig_reset (sig_reset),
    .rx_reset  (rx_reset),
    .ctrl      (ctrl),
    .rin       (rin),
    .half_tick (rx_half_tick),
    .restart   (rx_restart),
    .rx_status (rx_status),
    .rbr       (rbr)
  );

endmodule

//--- verification/tb_acia.sv
// testbench for the serial controller
// CRU bit write/read tasks, frame capture and line injection
// directed tests with a watchdog

`timescale 1ns/10ps

module tb_acia
  import acia_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int CLK_DIV     = 4;
  localparam int RATE_COUNT  = 2;
  localparam int HALF_CLKS   = RATE_COUNT * CLK_DIV;  // half-bit with div8 clear
  localparam int BIT_CLKS    = 2 * HALF_CLKS;
  localparam int FRAME_CLKS  = 16 * BIT_CLKS;         // frame plus idle and polling
  localparam int N_FRAMES    = 12;                    // 4 tx, 3 loopback, 4 error, 1 irq
  localparam int MARGIN_CLKS = 3000;                  // register programming
  localparam int WAIT_CLKS   = 2 * FRAME_CLKS;
  localparam int LIMIT_CLKS  = N_FRAMES * FRAME_CLKS + MARGIN_CLKS;

  logic      CLK = 1'b0;
  logic      sig_reset;
  logic      n_ce;
  logic      cru_clk;
  logic      cru_out;
  cru_addr_t s;
  logic      n_cts;
  logic      rin;
  logic      cru_in;
  logic      n_int;
  logic      n_rts;
  logic      xout;
  logic      loop_sel;   // 1 = xout looped to rin
  logic      inj_line;

  int          tests;
  int          checks;
  int          errors;
  int          test_errs;
  string       test_name;

  acia_top #(.CLK_DIV(CLK_DIV)) i_dut (
    .CLK       (CLK),
    .sig_reset (sig_reset),
    .n_ce      (n_ce),
    .cru_clk   (cru_clk),
    .cru_out   (cru_out),
    .s         (s),
    .n_cts     (n_cts),
    .rin       (rin),
    .cru_in    (cru_in),
    .n_int     (n_int),
    .n_rts     (n_rts),
    .xout      (xout)
  );

  assign rin = loop_sel ? xout : inj_line;

  initial
  begin
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // ==================================================
  // bookkeeping and checks
  // ==================================================
  task automatic open_test(input string name);
    test_name = name;
    test_errs = 0;
    tests++;
  endtask

  task automatic close_test();
    if (test_errs == 0)
      $display("test %s: passed", test_name);
    else
      $display("test %s: %0d error(s)", test_name, test_errs);
    errors += test_errs;
  endtask

  task automatic expect_bit(input string what, input logic exp, input logic act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_word(input string what, input logic [11:0] exp,
                              input logic [11:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  // ==================================================
  // CRU host access
  // ==================================================
  // one bit write whose falling strobe edge advances the load flags
  task automatic strobe_bit(input cru_addr_t addr, input logic val);
    @(posedge CLK);
    s       <= addr;
    cru_out <= val;
    n_ce    <= 1'b0;
    cru_clk <= 1'b1;
    @(posedge CLK);
    cru_clk <= 1'b0;
    @(posedge CLK);
    n_ce <= 1'b1;
  endtask

  task automatic read_bit(input cru_addr_t addr, output logic val);
    @(posedge CLK);
    s    <= addr;
    n_ce <= 1'b0;
    @(negedge CLK);
    val = cru_in;
    @(posedge CLK);
    n_ce <= 1'b1;
  endtask

  task automatic write_field(input logic [10:0] val, input int nbits);
    for (int i = 0; i < nbits; i++)
      strobe_bit(cru_addr_t'(i), val[i]);   // lsb first and top bit last
  endtask

  task automatic read_rx_byte(output logic [7:0] val);
    logic b;
    val = '0;
    for (int i = 0; i < 8; i++)
    begin
      read_bit(cru_addr_t'(i), b);
      val[i] = b;
    end
  endtask

  // poll a read bit until it has the wanted value
  task automatic poll_until(input cru_addr_t addr, input logic want, input string what);
    logic v;
    time  t_end;
    t_end = $time + WAIT_CLKS * CLK_PERIOD;
    read_bit(addr, v);
    while (v !== want && $time < t_end)
      read_bit(addr, v);
    assert (v === want)
    else
    begin
      $display("test %s: timed out waiting for %s", test_name, what);
      test_errs++;
    end
  endtask

  // soft reset then ctrl, both rates, end of xmit rate load and RTS on
  task automatic program_regs(input ctrl_t c);
    rate_t r;
    r = '{div8: 1'b0, count: 10'(RATE_COUNT)};
    strobe_bit(CRU_RESET, 1'b1);
    write_field({3'b000, c}, 8);
    write_field(r, 11);
    strobe_bit(CRU_LXDR, 1'b0);
    strobe_bit(CRU_RTSON, 1'b1);
  endtask

  task automatic send_byte(input logic [7:0] data);
    write_field({3'b000, data}, 8);   // bit 7 write loads the transmitter
  endtask

  // ==================================================
  // serial line helpers
  // ==================================================
  function automatic logic [7:0] char_mask(input ctrl_t c);
    return 8'hff >> (2'd3 - c.rcl);
  endfunction

  // start, data lsb first, parity if enabled and stop
  // unused bits stay at mark
  function automatic logic [11:0] frame_bits(input logic [7:0] data, input ctrl_t c);
    logic [11:0] f;
    int          n;
    n    = 5 + int'(c.rcl);
    f    = '1;
    f[0] = 1'b0;
    for (int i = 0; i < n; i++)
      f[i + 1] = data[i];
    if (c.penb)
      f[n + 1] = (^(data & char_mask(c))) ^ c.podd;
    return f;
  endfunction

  // wait for the start bit and sample each bit at its middle
  task automatic capture_frame(input int nsamp, output logic [11:0] bits,
                               output logic found);
    time t_end;
    t_end = $time + WAIT_CLKS * CLK_PERIOD;
    found = 1'b0;
    bits  = '1;
    while (!found && $time < t_end)
    begin
      @(negedge CLK);
      if (xout == 1'b0)
        found = 1'b1;
    end
    if (found)
    begin
      repeat (HALF_CLKS) @(negedge CLK);
      bits[0] = xout;
      for (int i = 1; i < nsamp; i++)
      begin
        repeat (BIT_CLKS) @(negedge CLK);
        bits[i] = xout;
      end
    end
  endtask

  // 8 data bits with even parity and 1 stop
  // parity and stop can be corrupted
  task automatic drive_frame(input logic [7:0] data, input logic bad_par,
                             input logic stop_val);
    logic [10:0] f;
    f = {stop_val, (^data) ^ bad_par, data, 1'b0};
    repeat (2 * BIT_CLKS) @(posedge CLK);   // mark gap
    for (int i = 0; i < 11; i++)
    begin
      @(posedge CLK);
      inj_line <= f[i];
      repeat (BIT_CLKS - 1) @(posedge CLK);
    end
    @(posedge CLK);
    inj_line <= 1'b1;
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic check_reset_state();
    logic v;
    open_test("reset_state");
    read_bit(RD_XBRE, v);
    expect_bit("xbre", 1'b1, v);
    read_bit(RD_XSRE, v);
    expect_bit("xsre", 1'b1, v);
    read_bit(RD_RBRL, v);
    expect_bit("rbrl", 1'b0, v);
    read_bit(RD_FLAG, v);
    expect_bit("flag", 1'b1, v);
    @(negedge CLK);
    expect_bit("n_int", 1'b1, n_int);
    expect_bit("n_rts", 1'b1, n_rts);
    close_test();
  endtask

  task automatic check_rts_programming();
    ctrl_t c;
    logic  v;
    open_test("program_rts");
    c = '{sbs: 2'b10, penb: 1'b1, podd: 1'b0, spare: 2'b00, rcl: 2'd3};
    program_regs(c);
    read_bit(RD_FLAG, v);
    expect_bit("flag", 1'b0, v);   // load sequence finished
    read_bit(RD_RTS, v);
    expect_bit("rts read", 1'b1, v);
    @(negedge CLK);
    expect_bit("n_rts", 1'b0, n_rts);
    close_test();
  endtask

  task automatic transmit_frames();
    ctrl_t       c;
    logic [7:0]  data;
    logic [11:0] exp_f;
    logic [11:0] got_f;
    logic        found;
    logic        v;
    open_test("transmit");
    @(posedge CLK);
    loop_sel <= 1'b1;
    for (int len = 0; len < 4; len++)
    begin
      c      = '0;
      c.rcl  = 2'(len);
      c.penb = 1'b1;
      c.podd = len[0];
      c.sbs  = 2'(len % 3);
      program_regs(c);
      data  = 8'($urandom);
      exp_f = frame_bits(data, c);
      send_byte(data);
      capture_frame(8 + len, got_f, found);   // start, data, parity, stop
      assert (found)
      else
      begin
        $display("test %s: no start bit seen on xout", test_name);
        test_errs++;
      end
      if (found)
        compare_word("frame", exp_f, got_f);
      poll_until(RD_XSRE, 1'b1, "xsre");
      read_bit(RD_XBRE, v);
      expect_bit("xbre", 1'b1, v);
    end
    close_test();
  endtask

  task automatic loopback_receive();
    ctrl_t      c;
    logic [7:0] data;
    logic [7:0] got;
    logic       v;
    open_test("loopback");
    @(posedge CLK);
    loop_sel <= 1'b1;
    for (int k = 0; k < 3; k++)
    begin
      c      = '0;
      c.rcl  = 2'(3 - k);
      c.penb = (k != 0);
      c.podd = k[0];
      c.sbs  = 2'(2 - k);
      program_regs(c);
      data = 8'($urandom);
      send_byte(data);
      poll_until(RD_RBRL, 1'b1, "rbrl");
      read_rx_byte(got);
      compare_word("data", {4'h0, data & char_mask(c)}, {4'h0, got});
      read_bit(RD_RCVERR, v);
      expect_bit("rcverr", 1'b0, v);
      read_bit(RD_RPER, v);
      expect_bit("rper", 1'b0, v);
      read_bit(RD_RFER, v);
      expect_bit("rfer", 1'b0, v);
      read_bit(RD_ROVER, v);
      expect_bit("rover", 1'b0, v);
      poll_until(RD_XSRE, 1'b1, "xsre");
    end
    close_test();
  endtask

  task automatic receive_errors();
    ctrl_t c;
    logic  v;
    open_test("errors");
    c = '{sbs: 2'b10, penb: 1'b1, podd: 1'b0, spare: 2'b00, rcl: 2'd3};
    program_regs(c);
    @(posedge CLK);
    loop_sel <= 1'b0;
    // wrong parity
    strobe_bit(CRU_RIENB, 1'b0);
    drive_frame(8'($urandom), 1'b1, 1'b1);
    poll_until(RD_RBRL, 1'b1, "rbrl after parity error");
    read_bit(RD_RPER, v);
    expect_bit("rper", 1'b1, v);
    read_bit(RD_RCVERR, v);
    expect_bit("rcverr", 1'b1, v);
    read_bit(RD_RFER, v);
    expect_bit("rfer clean", 1'b0, v);
    // zero stop bit
    strobe_bit(CRU_RIENB, 1'b0);
    drive_frame(8'($urandom), 1'b0, 1'b0);
    poll_until(RD_RBRL, 1'b1, "rbrl after framing error");
    read_bit(RD_RFER, v);
    expect_bit("rfer", 1'b1, v);
    // second frame while rbrl is still set
    strobe_bit(CRU_RIENB, 1'b0);
    drive_frame(8'($urandom), 1'b0, 1'b1);
    drive_frame(8'($urandom), 1'b0, 1'b1);
    poll_until(RD_RBRL, 1'b1, "rbrl after two frames");
    read_bit(RD_ROVER, v);
    expect_bit("rover", 1'b1, v);
    close_test();
  endtask

  task automatic interrupt_flags();
    ctrl_t c;
    logic  v;
    open_test("interrupts");
    c = '{sbs: 2'b10, penb: 1'b1, podd: 1'b0, spare: 2'b00, rcl: 2'd3};
    program_regs(c);
    @(posedge CLK);
    loop_sel <= 1'b0;
    strobe_bit(CRU_RIENB, 1'b1);
    @(negedge CLK);
    expect_bit("n_int idle", 1'b1, n_int);
    drive_frame(8'($urandom), 1'b0, 1'b1);
    poll_until(RD_RBRL, 1'b1, "rbrl");
    @(negedge CLK);
    expect_bit("n_int on rbrl", 1'b0, n_int);
    read_bit(RD_RINT, v);
    expect_bit("rint", 1'b1, v);
    strobe_bit(CRU_RIENB, 1'b1);   // receiver reset clears rbrl
    read_bit(RD_RBRL, v);
    expect_bit("rbrl cleared", 1'b0, v);
    @(negedge CLK);
    expect_bit("n_int cleared", 1'b1, n_int);
    strobe_bit(CRU_XIENB, 1'b1);
    @(negedge CLK);
    expect_bit("n_int on xbre", 1'b0, n_int);
    read_bit(RD_XINT, v);
    expect_bit("xint", 1'b1, v);
    read_bit(RD_INT, v);
    expect_bit("int", 1'b1, v);
    close_test();
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================
  initial
  begin
    void'($urandom(32'ha86ceea1));
    tests     = 0;
    checks    = 0;
    errors    = 0;
    test_errs = 0;
    sig_reset <= 1'b1;
    n_ce      <= 1'b1;
    cru_clk   <= 1'b0;
    cru_out   <= 1'b0;
    s         <= '0;
    n_cts     <= 1'b0;   // clear to send
    loop_sel  <= 1'b1;
    inj_line  <= 1'b1;   // mark
    repeat (4) @(posedge CLK);
    sig_reset <= 1'b0;
    check_reset_state();
    check_rts_programming();
    transmit_frames();
    loopback_receive();
    receive_errors();
    interrupt_flags();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    #(LIMIT_CLKS * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d clocks", LIMIT_CLKS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- filelist.f
design/acia_pkg.sv
design/cru_regs.sv
design/half_bit_timer.sv
design/serial_tx.sv
design/serial_rx.sv
design/acia_top.sv
verification/tb_acia.sv

//--- Makefile
# Verilator build, run, lint and clean for the serial controller

VERILATOR ?= verilator
TOP       ?= tb_acia
DUT_TOP   ?= acia_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
SOURCES   := $(wildcard design/*.sv verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
